//--- include/highpass_coeffs.svh
`ifndef HIGHPASS_COEFFS_SVH
`define HIGHPASS_COEFFS_SVH

// Unique taps of the highpass response, outermost pair first
// Entry k weights both x(n-k) and x(n-146+k)
localparam coeff_t COEFF_TABLE [NUM_COEFF] = '{
    // Outer skirt, almost zero
    16'h0000,
    16'h0000,
    16'h0000,
    16'h0000,
    16'h0001,
    16'h0001,
    16'h0002,
    16'h0004,
    16'h0004,
    16'h0004,
    16'h0003,
    16'h0001,
    16'hFFFD,
    16'hFFF8,
    16'hFFF3,
    16'hFFEE,
    16'hFFEB,
    16'hFFEB,
    16'hFFEE,
    16'hFFF5,
    16'hFFFF,
    16'h000C,
    16'h001B,
    16'h0029,
    16'h0033,
    16'h0038,
    16'h0036,
    16'h002B,
    16'h0017,
    16'hFFFD,
    16'hFFDE,
    16'hFFBF,
    16'hFFA4,
    16'hFF92,
    16'hFF8C,
    16'hFF96,
    16'hFFB1,
    16'hFFDA,
    16'h0010,
    16'h004B,
    16'h0084,
    16'h00B3,
    16'h00CF,
    16'h00D3,
    16'h00BA,
    16'h0084,
    16'h0034,
    16'hFFD1,
    16'hFF67,
    16'hFF03,
    16'hFEB5,
    16'hFE88,
    16'hFE8A,
    16'hFEBF,
    16'hFF29,
    16'hFFC0,
    16'h0079,
    16'h013F,
    16'h01F9,
    16'h028E,
    16'h02E3,
    16'h02E0,
    16'h0274,
    16'h0196,
    16'h0048,
    // Main negative lobe next to the centre
    16'hFE94,
    16'hFC91,
    16'hFA5D,
    16'hF81F,
    16'hF5FF,
    16'hF425,
    16'hF2B5,
    16'hF1CD,
    // Centre tap x(n-73), no mirror
    16'h717D
};

`endif

//--- hw/fir_types_pkg.sv
package fir_types_pkg;

    // Samples are two's complement at the filter input and output
    localparam int SAMPLE_W = 16;

    // One extra bit keeps the sum of a mirrored pair exact
    localparam int FOLD_W = SAMPLE_W + 1;

    // Coefficients are signed with 16 bits
    localparam int COEFF_W = 16;

    // Full precision of a folded sample times a coefficient
    localparam int PRODUCT_W = FOLD_W + COEFF_W;

    // Accumulator for the whole filter sum
    // 74 products need 7 guard bits, the rest is headroom
    localparam int ACC_W = 46;

    // One input or output sample
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Sum of two samples that share a coefficient
    typedef logic signed [FOLD_W-1:0] fold_t;

    // One filter coefficient
    typedef logic signed [COEFF_W-1:0] coeff_t;

    // Coefficient times fold value
    typedef logic signed [PRODUCT_W-1:0] product_t;

    // Exact sum of all product terms
    typedef logic signed [ACC_W-1:0] acc_t;

endpackage

//--- hw/fir_coeff_pkg.sv
package fir_coeff_pkg;

    import fir_types_pkg::*;

    // Filter length, odd so there is a single centre tap
    localparam int NUM_TAPS = 147;

    // Mirrored pairs plus the centre tap
    localparam int NUM_COEFF = (NUM_TAPS + 1) / 2;

    // Past samples kept in the delay line
    // x(n) itself comes straight from the input port
    localparam int DELAY_DEPTH = NUM_TAPS - 1;

    // Coefficient table, centre tap in the last entry
    `include "highpass_coeffs.svh"

endpackage

//--- hw/fir_delay_line.sv
`timescale 1ns/1ps

module fir_delay_line #(
    parameter int DEPTH = fir_coeff_pkg::DELAY_DEPTH
) (
    input  logic                  i_cs,
    input  fir_types_pkg::sample_t i_sample,
    output fir_types_pkg::sample_t o_taps [DEPTH],
    input  logic                  clk,
    input  logic                  rst_n
);

    import fir_types_pkg::*;

    // Tap j holds x(n-1-j) relative to the sample now on i_sample
    sample_t taps_q [DEPTH];

    always_ff @(posedge clk) begin
        if (rst_n) begin
            // Clear the whole history
            for (int i = 0; i < DEPTH; i++) begin
                taps_q[i] <= '0;
            end
        end else if (i_cs) begin
            // New sample enters at the head
            taps_q[0] <= i_sample;
            // Everything else moves one place down the chain
            for (int i = 1; i < DEPTH; i++) begin
                taps_q[i] <= taps_q[i-1];
            end
        end
        // Without the strobe the history holds
    end

    assign o_taps = taps_q;

endmodule

//--- hw/fir_fold_multiply.sv
`timescale 1ns/1ps

module fir_fold_multiply (
    input  fir_types_pkg::sample_t  i_sample,
    input  fir_types_pkg::sample_t  i_taps [fir_coeff_pkg::DELAY_DEPTH],
    output fir_types_pkg::product_t o_products [fir_coeff_pkg::NUM_COEFF]
);

    import fir_types_pkg::*;
    import fir_coeff_pkg::*;

    // Index of the unpaired middle tap
    localparam int CENTRE = NUM_COEFF - 1;

    // Position j carries x(n-j) over the whole filter span
    sample_t tap_pos [NUM_TAPS];
    // One folded value per unique coefficient
    fold_t   fold    [NUM_COEFF];

    // Current input is position 0
    assign tap_pos[0] = i_sample;

    // Delay line output k is x(n-1-k)
    for (genvar j = 1; j < NUM_TAPS; j++) begin : g_pos
        assign tap_pos[j] = i_taps[j-1];
    end

    // Linear phase lets mirrored taps share one multiplier
    // Both operands widen to 17 bits first so the sum never wraps
    for (genvar k = 0; k < CENTRE; k++) begin : g_fold
        assign fold[k] = fold_t'(tap_pos[k]) + fold_t'(tap_pos[NUM_TAPS-1-k]);
    end

    // Centre tap passes through alone
    assign fold[CENTRE] = fold_t'(tap_pos[CENTRE]);

    // Full precision signed multiply, 17 x 16 into 33 bits
    for (genvar k = 0; k < NUM_COEFF; k++) begin : g_mult
        assign o_products[k] = product_t'(fold[k]) * product_t'(COEFF_TABLE[k]);
    end

endmodule

//--- hw/fir_adder_tree.sv
`timescale 1ns/1ps

module fir_adder_tree #(
    parameter int NUM_TERMS = fir_coeff_pkg::NUM_COEFF
) (
    input  fir_types_pkg::product_t i_terms [NUM_TERMS],
    output fir_types_pkg::acc_t     o_sum
);

    import fir_types_pkg::*;

    // Pairwise levels until one value is left
    localparam int LEVELS = $clog2(NUM_TERMS);

    // Live entries at a given level of the tree
    function automatic int level_count(input int level);
        int span;
        span = 1 << level;
        return (NUM_TERMS + span - 1) / span;
    endfunction

    // Level 0 holds the inputs, level LEVELS holds the total
    acc_t lvl [LEVELS+1][NUM_TERMS];

    // Sign extend every term to the accumulator width up front
    for (genvar i = 0; i < NUM_TERMS; i++) begin : g_extend
        assign lvl[0][i] = acc_t'(i_terms[i]);
    end

    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        for (genvar i = 0; i < NUM_TERMS; i++) begin : g_node
            if (2*i + 1 < level_count(l)) begin : g_add
                // Both partners present
                assign lvl[l+1][i] = lvl[l][2*i] + lvl[l][2*i+1];
            end else if (2*i < level_count(l)) begin : g_carry
                // Odd leftover moves up unchanged
                assign lvl[l+1][i] = lvl[l][2*i];
            end else begin : g_idle
                // Slot beyond the live width of this level
                assign lvl[l+1][i] = '0;
            end
        end
    end

    // Exact sum regardless of the pairing order
    assign o_sum = lvl[LEVELS][0];

endmodule

//--- hw/highpass_fir.sv
`timescale 1ns/1ps

module highpass_fir #(
    parameter int OUT_SHIFT = 16
) (
    input  logic                   i_cs,
    input  fir_types_pkg::sample_t i_sample,
    output fir_types_pkg::sample_t o_filtered_sig,
    input  logic                   clk,
    input  logic                   rst_n
);

    import fir_types_pkg::*;
    import fir_coeff_pkg::*;

    // x(n-1) .. x(n-146)
    sample_t  taps     [DELAY_DEPTH];
    // Weighted pair sums
    product_t products [NUM_COEFF];
    // Exact filter sum and its scaled copy
    acc_t     sum;
    acc_t     sum_scaled;

    // Sample history, advances only on the strobe
    fir_delay_line #(
        .DEPTH (DELAY_DEPTH)
    ) u_delay_line (
        .i_cs     (i_cs),
        .i_sample (i_sample),
        .o_taps   (taps),
        .clk      (clk),
        .rst_n    (rst_n)
    );

    // Current sample joins the history for the fold
    fir_fold_multiply u_fold_multiply (
        .i_sample   (i_sample),
        .i_taps     (taps),
        .o_products (products)
    );

    // Combinational reduction to one value
    fir_adder_tree #(
        .NUM_TERMS (NUM_COEFF)
    ) u_adder_tree (
        .i_terms (products),
        .o_sum   (sum)
    );

    // Undo the coefficient gain, sign preserved
    assign sum_scaled = sum >>> OUT_SHIFT;

    // Low bits of the scaled sum, wraps on overflow
    always_ff @(posedge clk) begin
        if (rst_n) begin
            o_filtered_sig <= '0;
        end else if (i_cs) begin
            o_filtered_sig <= sum_scaled[SAMPLE_W-1:0];
        end
    end

endmodule

//--- verif/tb_highpass_fir.sv
`timescale 1ns/1ps

module tb_highpass_fir;

    import fir_types_pkg::*;
    import fir_coeff_pkg::*;

    // Clock and scaling
    localparam int PERIOD    = 20;
    localparam int OUT_SHIFT = 16;

    // Test lengths in cycles or samples
    localparam int RESET_CYCLES = 3;
    localparam int IDLE_CYCLES  = 10;
    localparam int GATED_LEN    = 120;
    localparam int GAP_EVERY    = 10;
    localparam int MAX_GAP      = 4;
    localparam int RANDOM_LEN   = 400;
    localparam int ALT_LEN      = 200;
    localparam int MID_PRE      = 50;
    localparam int MID_POST     = 160;
    localparam int TAIL_CYCLES  = 5;

    // Worst case length of the whole run, gaps at their longest
    localparam int TOTAL_CYCLES = 2 * (RESET_CYCLES + 1) + IDLE_CYCLES + NUM_TAPS
                                + GATED_LEN + (GATED_LEN / GAP_EVERY) * MAX_GAP
                                + RANDOM_LEN + ALT_LEN + MID_PRE + MID_POST + TAIL_CYCLES;
    localparam int MARGIN       = 100;
    localparam int WATCHDOG_NS  = (TOTAL_CYCLES + MARGIN) * PERIOD;

    localparam sample_t IMPULSE_AMP = 16'sh4000;

    logic    clk;
    logic    rst_n;
    logic    i_cs;
    sample_t i_sample;
    sample_t o_filtered_sig;

    // Model state: strobed history, newest first
    sample_t hist [NUM_TAPS];
    // Output the DUT should load on the next strobed edge
    sample_t model_next;
    // Expected content of the output register
    sample_t exp_out;
    // Previous edge values for the hold and reset checks
    sample_t prev_out;
    logic    prev_cs;
    logic    prev_rst;

    int   seed = 32'h3227;
    int   errors = 0;
    logic check_en = 1'b0;

    highpass_fir #(
        .OUT_SHIFT (OUT_SHIFT)
    ) u_highpass_fir (
        .i_cs           (i_cs),
        .i_sample       (i_sample),
        .o_filtered_sig (o_filtered_sig),
        .clk            (clk),
        .rst_n          (rst_n)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // Exact direct-form sum over all 147 taps, then scale and truncate
    function automatic sample_t model_output();
        longint acc;
        int     c;
        acc = 0;
        for (int t = 0; t < NUM_TAPS; t++) begin
            // Mirror index, centre maps to the last entry
            c = (t < NUM_TAPS - 1 - t) ? t : NUM_TAPS - 1 - t;
            acc += longint'(hist[t]) * longint'(COEFF_TABLE[c]);
        end
        acc = acc >>> OUT_SHIFT;
        return sample_t'(acc[SAMPLE_W-1:0]);
    endfunction

    function automatic void push_history(input sample_t s);
        for (int i = NUM_TAPS - 1; i > 0; i--) begin
            hist[i] = hist[i-1];
        end
        hist[0] = s;
    endfunction

    // Output register as the model sees it
    always @(posedge clk) begin
        if (rst_n) begin
            exp_out <= '0;
        end else if (i_cs) begin
            exp_out <= model_next;
        end
        prev_out <= o_filtered_sig;
        prev_cs  <= i_cs;
        prev_rst <= rst_n;
    end

    // Output against the model after every edge
    assert property (@(posedge clk) check_en |-> o_filtered_sig == exp_out)
        else begin
            errors++;
            $display("ERR t=%0t o_filtered_sig expected %0d got %0d",
                     $time, exp_out, o_filtered_sig);
        end

    // Output holds through an edge without the strobe
    assert property (@(posedge clk)
                     (check_en && !prev_cs && !prev_rst) |-> o_filtered_sig == prev_out)
        else begin
            errors++;
            $display("ERR t=%0t o_filtered_sig expected %0d got %0d (hold)",
                     $time, prev_out, o_filtered_sig);
        end

    // Reset clears the output
    assert property (@(posedge clk) (check_en && prev_rst) |-> o_filtered_sig == '0)
        else begin
            errors++;
            $display("ERR t=%0t o_filtered_sig expected 0 got %0d (reset)",
                     $time, o_filtered_sig);
        end

    // One strobed sample, model advances with it
    task automatic strobe(input sample_t s);
        @(negedge clk);
        i_cs     = 1'b1;
        i_sample = s;
        push_history(s);
        model_next = model_output();
    endtask

    // Cycles without the strobe, optionally with junk on the data input
    task automatic idle(input int n, input bit junk);
        repeat (n) begin
            @(negedge clk);
            i_cs     = 1'b0;
            i_sample = junk ? sample_t'($random(seed)) : '0;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b1;
        i_cs  = 1'b0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            hist[i] = '0;
        end
        model_next = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b0;
    endtask

    // Single pulse, output k should be amplitude times coefficient k
    task automatic impulse_test();
        int c;
        for (int k = 0; k < NUM_TAPS; k++) begin
            strobe((k == 0) ? IMPULSE_AMP : sample_t'(0));
            c = (k < NUM_TAPS - 1 - k) ? k : NUM_TAPS - 1 - k;
            model_next = sample_t'((longint'(IMPULSE_AMP) * longint'(COEFF_TABLE[c]))
                                   >>> OUT_SHIFT);
        end
    endtask

    task automatic gated_test();
        int gap;
        for (int i = 0; i < GATED_LEN; i++) begin
            strobe(sample_t'($random(seed)));
            if ((i % GAP_EVERY) == GAP_EVERY - 1) begin
                gap = 1 + int'($unsigned($random(seed)) % 32'd4);
                idle(gap, 1'b1);
            end
        end
    endtask

    task automatic random_test(input int n);
        repeat (n) strobe(sample_t'($random(seed)));
    endtask

    // Full scale at Nyquist drives the highpass into wrap
    task automatic alternating_test();
        for (int i = 0; i < ALT_LEN; i++) begin
            strobe((i % 2 == 0) ? 16'sh7FFF : 16'sh8000);
        end
    endtask

    initial begin
        // Reset held from time zero
        rst_n      = 1'b1;
        i_cs       = 1'b0;
        i_sample   = '0;
        model_next = '0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            hist[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n    = 1'b0;
        check_en = 1'b1;

        idle(IDLE_CYCLES, 1'b0);
        impulse_test();
        gated_test();
        random_test(RANDOM_LEN);
        alternating_test();

        // Reset in the middle of a stream
        random_test(MID_PRE);
        apply_reset();
        random_test(MID_POST);

        idle(TAIL_CYCLES, 1'b1);
        $display("Run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog sized from the test lengths
    initial begin
        #(WATCHDOG_NS);
        $display("Simulation timed out before the tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
hw/fir_types_pkg.sv
hw/fir_coeff_pkg.sv
hw/fir_delay_line.sv
hw/fir_fold_multiply.sv
hw/fir_adder_tree.sv
hw/highpass_fir.sv
verif/tb_highpass_fir.sv

//--- Makefile
# Verilator build and run of the FIR testbench

VERILATOR ?= verilator
TOP       ?= tb_highpass_fir
FLAGS     ?= --binary --timing --assert
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, pass if NO ERRORS is printed"
	@echo "  clean  remove build output"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLAGS FILELIST OBJ_DIR"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
